/* all.f */
hdl/alu_pkg.sv
hdl/sync_fifo.sv
hdl/alu.sv
hdl/alu_exec.sv
hdl/apb_alu_regs.sv
hdl/alu_copro_top.sv
test/tb_alu_copro.sv

/* run_sim.sh */
#!/bin/sh
# Builds the ALU coprocessor testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert -f all.f --top-module tb_alu_copro -o sim_alu_copro
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_alu_copro > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
exit 0

/* test/tb_alu_copro.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_alu_copro;

  localparam int NUM_TXN    = 47; // commands plus the single error and status accesses.
  localparam int MAX_CYCLES = 200 * NUM_TXN;

  logic           clk = 1'b0;
  logic           rst;
  logic [7:0]     paddr;
  logic           psel;
  logic           penable;
  logic           pwrite;
  alu_pkg::word_t pwdata;
  alu_pkg::word_t prdata;
  logic           pready;
  logic           pslverr;
  integer         seed;
  int             cycles = 0;
  alu_pkg::word_t expected_q[$];

  alu_copro_top UUT (
    .clk (clk), .rst (rst), .paddr (paddr), .psel (psel), .penable (penable),
    .pwrite (pwrite), .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** FAILED ***");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  // ============================================================
  // reference model
  // ============================================================
  function automatic alu_pkg::word_t model_result(input alu_pkg::alu_op_t op, input logic inv,
                                                  input alu_pkg::word_t l, input alu_pkg::word_t r);
    alu_pkg::word_t v;
    logic [4:0]     sh;
    sh = r[4:0];
    case (op)
      alu_pkg::alu_and:  v = l & r;
      alu_pkg::alu_or:   v = l | r;
      alu_pkg::alu_xor:  v = l ^ r;
      alu_pkg::alu_add:  v = l + r;
      alu_pkg::alu_sub:  v = l - r;
      alu_pkg::alu_sll:  v = l << sh;
      alu_pkg::alu_srl:  v = l >> sh;
      alu_pkg::alu_sra:  v = (l >> sh) | (l[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      alu_pkg::alu_sltu: v = {31'b0, l < r};
      alu_pkg::alu_slt:  v = {31'b0, {~l[31], l[30:0]} < {~r[31], r[30:0]}}; // offset binary.
      alu_pkg::alu_eq:   v = {31'b0, l == r};
      alu_pkg::alu_mul:  v = l * r;
      default:           v = '0;
    endcase
    return inv ? ~v : v;
  endfunction

  function automatic alu_pkg::alu_op_t random_op(input int num_ops);
    alu_pkg::word_t w;
    w = $random(seed);
    return alu_pkg::alu_op_t'(4'(w % 32'(num_ops)));
  endfunction

  task automatic check_word(input string what, input alu_pkg::word_t got,
                            input alu_pkg::word_t exp);
    assert (got === exp) else begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "stopped at the first error");
    end
  endtask

  // ============================================================
  // APB access
  // ============================================================
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input alu_pkg::word_t wdata,
                          output alu_pkg::word_t rdata, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk); // access phase outputs are settled here.
    rdata = prdata;
    err   = pslverr;
    check_word("pready", 32'(pready), 32'd1);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic issue_cmd(input alu_pkg::alu_op_t op, input logic inv,
                           input alu_pkg::word_t l, input alu_pkg::word_t r);
    alu_pkg::word_t d;
    logic           e;
    logic           full_exp;
    full_exp = (expected_q.size() == 2 * alu_pkg::FIFO_DEPTH); // both queues hold work.
    apb_xfer(1'b1, alu_pkg::REG_LEFT, l, d, e);
    check_word("left write pslverr", 32'(e), 32'd0);
    apb_xfer(1'b1, alu_pkg::REG_RIGHT, r, d, e);
    check_word("right write pslverr", 32'(e), 32'd0);
    apb_xfer(1'b1, alu_pkg::REG_CTRL, {27'b0, inv, op}, d, e);
    check_word("ctrl write pslverr", 32'(e), 32'(full_exp));
    if (!full_exp) expected_q.push_back(model_result(op, inv, l, r));
  endtask

  task automatic read_result();
    alu_pkg::word_t d;
    logic           e;
    d = '0;
    while (d[2:0] == 3'd0) begin
      apb_xfer(1'b0, alu_pkg::REG_STATUS, '0, d, e);
    end
    apb_xfer(1'b0, alu_pkg::REG_RESULT, '0, d, e);
    check_word("result read pslverr", 32'(e), 32'd0);
    check_word("result", d, expected_q.pop_front());
  endtask

  task automatic check_status();
    alu_pkg::word_t d;
    logic           e;
    int             n;
    int             in_res;
    n      = expected_q.size();
    in_res = (n > alu_pkg::FIFO_DEPTH) ? alu_pkg::FIFO_DEPTH : n;
    repeat (12) @(posedge clk);
    apb_xfer(1'b0, alu_pkg::REG_STATUS, '0, d, e);
    check_word("status read pslverr", 32'(e), 32'd0);
    check_word("status", d, {25'b0, 3'(n - in_res), 1'b0, 3'(in_res)});
  endtask

  task automatic check_error(input logic wr, input logic [7:0] addr, input string what);
    alu_pkg::word_t d;
    logic           e;
    apb_xfer(wr, addr, 32'hdead_beef, d, e);
    check_word({what, " pslverr"}, 32'(e), 32'd1);
    check_word({what, " read data"}, d, 32'd0);
  endtask

  // ============================================================
  // test sequence
  // ============================================================
  initial begin
    alu_pkg::word_t   l;
    alu_pkg::word_t   r;
    alu_pkg::alu_op_t op;
    seed    = 32'h2046_e5cc;
    rst     = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    check_error(1'b1, 8'h14, "unmapped write");
    check_error(1'b0, 8'h14, "unmapped read");
    check_error(1'b0, 8'h02, "unaligned read");
    check_error(1'b0, alu_pkg::REG_RESULT, "empty result read");

    for (int pass = 0; pass < 2; pass++) begin
      for (int k = 0; k < 12; k++) begin
        op = alu_pkg::alu_op_t'(4'(k));
        l  = $random(seed);
        r  = (pass == 0 && op == alu_pkg::alu_eq) ? l : $random(seed); // hit the true case once.
        issue_cmd(op, 1'($random(seed)), l, r);
        read_result();
      end
    end

    for (int k = 0; k < 6; k++) begin
      op = (k % 2 == 0) ? alu_pkg::alu_mul : random_op(11); // multiply against the rest.
      issue_cmd(op, 1'($random(seed)), $random(seed), $random(seed));
    end
    check_status();
    while (expected_q.size() > 0) read_result();

    for (int k = 0; k < 9; k++) begin
      issue_cmd(random_op(12), 1'($random(seed)), $random(seed), $random(seed));
    end
    check_status();
    while (expected_q.size() > 0) read_result();
    check_error(1'b0, alu_pkg::REG_RESULT, "drained result read");
    check_status();

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/alu_copro_top.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_copro_top (
  input  wire                  clk,
  input  wire                  rst,
  input  wire alu_pkg::addr_t  paddr,
  input  wire                  psel,
  input  wire                  penable,
  input  wire                  pwrite,
  input  wire alu_pkg::word_t  pwdata,
  output alu_pkg::word_t       prdata,
  output logic                 pready,
  output logic                 pslverr
);

  logic                      cmd_push;
  logic [alu_pkg::CMD_W-1:0] cmd_data;
  logic                      cmd_pop;
  logic [alu_pkg::CMD_W-1:0] cmd_q_data;
  alu_pkg::count_t           cmd_count;
  logic                      cmd_full;
  logic                      cmd_empty;
  logic                      res_push;
  alu_pkg::word_t            res_data;
  logic                      res_pop;
  alu_pkg::word_t            res_q_data;
  alu_pkg::count_t           res_count;
  logic                      res_empty;

  apb_alu_regs u_regs (
    .clk (clk), .rst (rst),
    .paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite), .pwdata (pwdata),
    .cmd_full (cmd_full), .cmd_count (cmd_count),
    .res_data (res_q_data), .res_empty (res_empty), .res_count (res_count),
    .prdata (prdata), .pready (pready), .pslverr (pslverr),
    .cmd_push (cmd_push), .cmd_data (cmd_data), .res_pop (res_pop)
  );

  sync_fifo #(.WIDTH(alu_pkg::CMD_W)) cmd_q (
    .clk (clk), .rst (rst), .push (cmd_push), .wdata (cmd_data), .pop (cmd_pop),
    .rdata (cmd_q_data), .count (cmd_count), .full (cmd_full), .empty (cmd_empty)
  );

  // full is unused here, the execution unit tracks room by credits.
  sync_fifo #(.WIDTH(32)) res_q (
    .clk (clk), .rst (rst), .push (res_push), .wdata (res_data), .pop (res_pop),
    .rdata (res_q_data), .count (res_count), .full (), .empty (res_empty)
  );

  alu_exec u_exec (
    .clk (clk), .rst (rst),
    .cmd_data (cmd_q_data), .cmd_empty (cmd_empty), .res_count (res_count),
    .cmd_pop (cmd_pop), .res_push (res_push), .res_data (res_data)
  );

endmodule

`default_nettype wire

/* hdl/apb_alu_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_alu_regs (
  input  wire                         clk,
  input  wire                         rst,
  input  wire alu_pkg::addr_t         paddr,
  input  wire                         psel,
  input  wire                         penable,
  input  wire                         pwrite,
  input  wire alu_pkg::word_t         pwdata,
  input  wire                         cmd_full,
  input  wire alu_pkg::count_t        cmd_count,
  input  wire alu_pkg::word_t         res_data,
  input  wire                         res_empty,
  input  wire alu_pkg::count_t        res_count,
  output alu_pkg::word_t              prdata,
  output logic                        pready,
  output logic                        pslverr,
  output logic                        cmd_push,
  output logic [alu_pkg::CMD_W-1:0]   cmd_data,
  output logic                        res_pop
);

  logic            wr_access;
  logic            rd_access;
  logic            addr_ok;
  alu_pkg::word_t  left_q;
  alu_pkg::word_t  right_q;
  alu_pkg::alu_op_t ctrl_op;
  logic            ctrl_inv;

  assign wr_access = psel && penable && pwrite;
  assign rd_access = psel && penable && !pwrite;

  assign addr_ok = paddr inside {alu_pkg::REG_LEFT, alu_pkg::REG_RIGHT, alu_pkg::REG_CTRL,
                                 alu_pkg::REG_RESULT, alu_pkg::REG_STATUS};

  assign pready = 1'b1; // no wait states.

  // ============================================================
  // operand registers
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      left_q  <= '0;
      right_q <= '0;
    end else if (wr_access) begin
      if (paddr == alu_pkg::REG_LEFT) left_q <= pwdata;
      if (paddr == alu_pkg::REG_RIGHT) right_q <= pwdata;
    end
  end

  // ============================================================
  // command push and result pop
  // ============================================================
  assign ctrl_op  = alu_pkg::alu_op_t'(pwdata[3:0]);
  assign ctrl_inv = pwdata[4];
  assign cmd_data = {ctrl_op, ctrl_inv, left_q, right_q};

  assign cmd_push = wr_access && (paddr == alu_pkg::REG_CTRL) && !cmd_full;
  assign res_pop  = rd_access && (paddr == alu_pkg::REG_RESULT) && !res_empty;

  always_comb begin
    pslverr = 1'b0;
    if (psel && penable) begin
      if (!addr_ok) pslverr = 1'b1;
      if (wr_access && paddr == alu_pkg::REG_CTRL && cmd_full) pslverr = 1'b1;
      if (rd_access && paddr == alu_pkg::REG_RESULT && res_empty) pslverr = 1'b1;
    end
  end

  always_comb begin
    prdata = '0;
    if (rd_access) begin
      case (paddr)
        alu_pkg::REG_RESULT: prdata = res_empty ? '0 : res_data;
        alu_pkg::REG_STATUS: prdata = {25'b0, cmd_count, 1'b0, res_count};
        default:             prdata = '0; // operand and control registers read as zero.
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/alu_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
  input  wire                        clk,
  input  wire                        rst,
  input  wire [alu_pkg::CMD_W-1:0]   cmd_data,
  input  wire                        cmd_empty,
  input  wire alu_pkg::count_t       res_count,
  output logic                       cmd_pop,
  output logic                       res_push,
  output alu_pkg::word_t             res_data
);

  logic                                         alu_in_valid;
  alu_pkg::alu_op_t                             alu_op;
  logic                                         alu_inv;
  alu_pkg::word_t                               alu_left;
  alu_pkg::word_t                               alu_right;
  logic                                         alu_out_valid;
  alu_pkg::word_t                               alu_res;
  logic [$clog2(alu_pkg::ALU_LATENCY + 1)-1:0] in_flight;
  logic [3:0]                                   credit_used;
  logic                                         credit_ok;

  // ============================================================
  // credit check
  // ============================================================
  assign credit_used = 4'(res_count) + 4'(in_flight);
  assign credit_ok   = credit_used < 4'(alu_pkg::FIFO_DEPTH); // room for every result issued.

  assign alu_in_valid = !cmd_empty && credit_ok;
  assign cmd_pop      = alu_in_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= '0;
    end else begin
      case ({alu_in_valid, alu_out_valid})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
    end
  end

  assign alu_op    = alu_pkg::alu_op_t'(cmd_data[alu_pkg::CMD_W-1 -: 4]);
  assign alu_inv   = cmd_data[64];
  assign alu_left  = cmd_data[63:32];
  assign alu_right = cmd_data[31:0];

  alu u_alu (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (alu_in_valid),
    .op        (alu_op),
    .inv       (alu_inv),
    .left      (alu_left),
    .right     (alu_right),
    .out_valid (alu_out_valid),
    .res       (alu_res)
  );

  assign res_push = alu_out_valid;
  assign res_data = alu_res;

  assert property (@(posedge clk) disable iff (rst)
    res_push |-> res_count != alu_pkg::count_t'(alu_pkg::FIFO_DEPTH))
    else $error("result pushed while the result FIFO is full.");

endmodule

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   in_valid,
  input  wire alu_pkg::alu_op_t op,
  input  wire                   inv,
  input  wire alu_pkg::word_t   left,
  input  wire alu_pkg::word_t   right,
  output logic                  out_valid,
  output alu_pkg::word_t        res
);

  alu_pkg::word_t   s1_next;
  alu_pkg::word_t   s1_res;
  alu_pkg::word_t   s1_left;
  alu_pkg::word_t   s1_right;
  alu_pkg::alu_op_t s1_op;
  logic             s1_inv;
  logic             s1_valid;
  alu_pkg::word_t   product;
  alu_pkg::word_t   s2_sel;
  logic [alu_pkg::SHAMT_W-1:0] shamt;

  assign shamt = right[alu_pkg::SHAMT_W-1:0];

  // ============================================================
  // stage 1
  // ============================================================
  always_comb begin
    case (op)
      alu_pkg::alu_and:  s1_next = left & right;
      alu_pkg::alu_or:   s1_next = left | right;
      alu_pkg::alu_xor:  s1_next = left ^ right;
      alu_pkg::alu_add:  s1_next = left + right;
      alu_pkg::alu_sub:  s1_next = left - right;
      alu_pkg::alu_sll:  s1_next = left << shamt;
      alu_pkg::alu_srl:  s1_next = left >> shamt;
      alu_pkg::alu_sra:  s1_next = alu_pkg::word_t'($signed(left) >>> shamt);
      alu_pkg::alu_sltu: s1_next = {31'b0, left < right};
      alu_pkg::alu_slt:  s1_next = {31'b0, $signed(left) < $signed(right)};
      alu_pkg::alu_eq:   s1_next = {31'b0, left == right};
      default:           s1_next = '0; // multiply finishes in stage 2.
    endcase
  end

  always_ff @(posedge clk) begin
    s1_res   <= s1_next;
    s1_left  <= left;
    s1_right <= right;
    s1_op    <= op;
    s1_inv   <= inv;
  end

  // ============================================================
  // stage 2
  // ============================================================
  assign product = s1_left * s1_right; // low half of the product only.
  assign s2_sel  = (s1_op == alu_pkg::alu_mul) ? product : s1_res;

  always_ff @(posedge clk) begin
    res <= s1_inv ? ~s2_sel : s2_sel;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= in_valid;
      out_valid <= s1_valid;
    end
  end

  assert property (@(posedge clk) disable iff (rst) in_valid |-> !$isunknown(op))
    else $error("unknown op issued to the ALU.");

endmodule

`default_nettype wire

/* hdl/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = 32
) (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  push,
  input  wire [WIDTH-1:0]      wdata,
  input  wire                  pop,
  output logic [WIDTH-1:0]     rdata,
  output alu_pkg::count_t      count,
  output logic                 full,
  output logic                 empty
);

  logic [WIDTH-1:0]          mem [alu_pkg::FIFO_DEPTH];
  logic [alu_pkg::PTR_W-1:0] wr_ptr;
  logic [alu_pkg::PTR_W-1:0] rd_ptr;

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, pointers wrap.
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign rdata = mem[rd_ptr]; // show-ahead head entry.
  assign full  = (count == alu_pkg::count_t'(alu_pkg::FIFO_DEPTH));
  assign empty = (count == '0);

  assert property (@(posedge clk) disable iff (rst) push |-> !full)
    else $error("push into a full FIFO.");

  assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
    else $error("pop from an empty FIFO.");

endmodule

`default_nettype wire

/* hdl/alu_pkg.sv */
`default_nettype none

package alu_pkg;

  // ============================================================
  // widths
  // ============================================================
  typedef logic [31:0] word_t;  // operand and result word.
  typedef logic [7:0]  addr_t;  // APB byte address.
  typedef logic [2:0]  count_t; // FIFO occupancy, 0 to FIFO_DEPTH.

  localparam int SHAMT_W = 5; // shifts use the low bits of the right operand.

  // ============================================================
  // operations
  // ============================================================
  typedef enum logic [3:0] {
    alu_and  = 4'd0,
    alu_or   = 4'd1,
    alu_xor  = 4'd2,
    alu_add  = 4'd3,
    alu_sub  = 4'd4,
    alu_sll  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_sltu = 4'd8,
    alu_slt  = 4'd9,
    alu_eq   = 4'd10,
    alu_mul  = 4'd11
  } alu_op_t;

  // command is {op, inv, left, right} from the top bit down.
  localparam int CMD_W = 4 + 1 + 32 + 32;

  localparam int FIFO_DEPTH  = 4;
  localparam int PTR_W       = $clog2(FIFO_DEPTH);
  localparam int ALU_LATENCY = 2; // cycles from in_valid to out_valid.

  // ============================================================
  // register map
  // ============================================================
  localparam addr_t REG_LEFT   = 8'h00;
  localparam addr_t REG_RIGHT  = 8'h04;
  localparam addr_t REG_CTRL   = 8'h08;
  localparam addr_t REG_RESULT = 8'h0C;
  localparam addr_t REG_STATUS = 8'h10;

endpackage

`default_nettype wire
